/* source/cordic_pkg.sv */
package cordic_pkg;

    // datapath widths
    localparam int data_w   = 14;
    localparam int sample_w = 8;

    // fraction bits: external Q1.6, coordinates Q1.12, angles Q2.11
    localparam int frac_in  = 6;
    localparam int frac_int = 12;

    localparam int max_stages = 12;

    typedef logic signed [sample_w-1:0] sample_t;
    typedef logic signed [data_w-1:0]   coord_t;
    typedef logic signed [data_w-1:0]   angle_t;

    // atan(2^-i) in Q2.11, rounded
    localparam angle_t atan_table [0:max_stages-1] = '{
        14'sd1608, 14'sd950, 14'sd502, 14'sd255,
        14'sd128,  14'sd64,  14'sd32,  14'sd16,
        14'sd8,    14'sd4,   14'sd2,   14'sd1
    };

    // pi/2 in Q2.11
    localparam angle_t half_pi = 14'sd3217;

    // 1/K = 0.60725 in Q1.12, starting x of every rotation
    localparam coord_t cordic_gain_init = 14'sd2487;

endpackage

/* source/angle_prep.sv */
`timescale 1ns/1ns

module angle_prep (
    input  logic                clk,
    input  logic                rst_n,
    input  cordic_pkg::sample_t angle,
    output logic                angle_sign,
    output cordic_pkg::angle_t  cos_angle,
    output cordic_pkg::angle_t  sin_angle
);
    import cordic_pkg::*;

    // Q1.6 to Q2.11 is a left shift by the difference in fraction bits
    localparam int ang_shift = (frac_int - 1) - frac_in;

    angle_t angle_ext;
    angle_t angle_mag;
    angle_t angle_scaled;

    // sign extend then fold to magnitude
    always_comb begin
        angle_ext = angle_t'(angle);
        if (angle[sample_w-1]) begin
            angle_mag = -angle_ext;
        end else begin
            angle_mag = angle_ext;
        end
        angle_scaled = angle_mag <<< ang_shift;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            angle_sign <= 1'b0;
            cos_angle  <= '0;
            sin_angle  <= '0;
        end else begin
            angle_sign <= angle[sample_w-1];
            cos_angle  <= angle_scaled;
            // sine comes from cos(pi/2 - a)
            sin_angle  <= half_pi - angle_scaled;
        end
    end

endmodule

/* source/cordic_stage.sv */
`timescale 1ns/1ns

module cordic_stage #(
    parameter int shift = 0
) (
    input  logic               clk,
    input  logic               rst_n,
    input  cordic_pkg::coord_t x_in,
    input  cordic_pkg::coord_t y_in,
    input  cordic_pkg::angle_t z_in,
    output cordic_pkg::coord_t x_out,
    output cordic_pkg::coord_t y_out,
    output cordic_pkg::angle_t z_out
);
    import cordic_pkg::*;

    coord_t x_shifted;
    coord_t y_shifted;
    logic   z_neg;

    assign x_shifted = x_in >>> shift;
    assign y_shifted = y_in >>> shift;
    assign z_neg     = z_in[data_w-1];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            x_out <= '0;
            y_out <= '0;
            z_out <= '0;
        end else if (z_neg) begin
            // residual below zero, rotate clockwise
            x_out <= x_in + y_shifted;
            y_out <= y_in - x_shifted;
            z_out <= z_in + atan_table[shift];
        end else begin
            x_out <= x_in - y_shifted;
            y_out <= y_in + x_shifted;
            z_out <= z_in - atan_table[shift];
        end
    end

endmodule

/* source/cordic_rotator.sv */
`timescale 1ns/1ns

module cordic_rotator #(
    parameter int num_stages = cordic_pkg::max_stages
) (
    input  logic               clk,
    input  logic               rst_n,
    input  cordic_pkg::angle_t z_start,
    output cordic_pkg::coord_t x_result
);
    import cordic_pkg::*;

    // x runs one entry longer, y and z of the last stage go nowhere
    coord_t x_pipe [0:num_stages];
    coord_t y_pipe [0:num_stages-1];
    angle_t z_pipe [0:num_stages-1];

    // start on the x axis, pre-scaled by the inverse gain
    assign x_pipe[0] = cordic_gain_init;
    assign y_pipe[0] = '0;
    assign z_pipe[0] = z_start;

    genvar i;
    generate
        for (i = 0; i < num_stages; i++) begin : g_stage
            if (i < num_stages - 1) begin : g_mid
                cordic_stage #(.shift(i)) u_stage (
                    .clk   (clk),
                    .rst_n (rst_n),
                    .x_in  (x_pipe[i]),
                    .y_in  (y_pipe[i]),
                    .z_in  (z_pipe[i]),
                    .x_out (x_pipe[i+1]),
                    .y_out (y_pipe[i+1]),
                    .z_out (z_pipe[i+1])
                );
            end else begin : g_last
                cordic_stage #(.shift(i)) u_stage (
                    .clk   (clk),
                    .rst_n (rst_n),
                    .x_in  (x_pipe[i]),
                    .y_in  (y_pipe[i]),
                    .z_in  (z_pipe[i]),
                    .x_out (x_pipe[i+1]),
                    .y_out (),
                    .z_out ()
                );
            end
        end
    endgenerate

    assign x_result = x_pipe[num_stages];

endmodule

/* source/result_combine.sv */
`timescale 1ns/1ns

module result_combine #(
    parameter int num_stages = cordic_pkg::max_stages
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                angle_sign,
    input  cordic_pkg::coord_t  cos_x,
    input  cordic_pkg::coord_t  sin_x,
    output cordic_pkg::sample_t sine,
    output cordic_pkg::sample_t cosine
);
    import cordic_pkg::*;

    localparam int drop_bits = frac_int - frac_in;
    // half an output LSB in Q1.12
    localparam coord_t round_half = coord_t'(1) <<< (drop_bits - 1);

    // sign travels alongside the rotators
    logic [num_stages-1:0] sign_pipe;
    logic                  sign_dly;

    coord_t sin_round;
    coord_t cos_round;
    coord_t sin_signed;

    assign sign_dly = sign_pipe[num_stages-1];

    always_comb begin
        sin_round = (sin_x + round_half) >>> drop_bits;
        cos_round = (cos_x + round_half) >>> drop_bits;
        if (sign_dly) begin
            sin_signed = -sin_round;
        end else begin
            sin_signed = sin_round;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sign_pipe <= '0;
        end else begin
            sign_pipe <= {sign_pipe[num_stages-2:0], angle_sign};
        end
    end

    // output register, Q1.6 results
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sine   <= '0;
            cosine <= '0;
        end else begin
            sine   <= sample_t'(sin_signed);
            cosine <= sample_t'(cos_round);
        end
    end

endmodule

/* source/cordic_top.sv */
`timescale 1ns/1ns

module cordic_top #(
    parameter int num_stages = cordic_pkg::max_stages
) (
    input  logic                clk,
    input  logic                rst_n,
    input  cordic_pkg::sample_t angle,
    output cordic_pkg::sample_t sine,
    output cordic_pkg::sample_t cosine
);
    import cordic_pkg::*;

    logic   angle_sign;
    angle_t cos_angle;
    angle_t sin_angle;
    coord_t cos_x;
    coord_t sin_x;

    angle_prep u_prep (
        .clk        (clk),
        .rst_n      (rst_n),
        .angle      (angle),
        .angle_sign (angle_sign),
        .cos_angle  (cos_angle),
        .sin_angle  (sin_angle)
    );

    // both rotators run in lockstep
    cordic_rotator #(.num_stages(num_stages)) u_cos_rot (
        .clk      (clk),
        .rst_n    (rst_n),
        .z_start  (cos_angle),
        .x_result (cos_x)
    );

    cordic_rotator #(.num_stages(num_stages)) u_sin_rot (
        .clk      (clk),
        .rst_n    (rst_n),
        .z_start  (sin_angle),
        .x_result (sin_x)
    );

    result_combine #(.num_stages(num_stages)) u_combine (
        .clk        (clk),
        .rst_n      (rst_n),
        .angle_sign (angle_sign),
        .cos_x      (cos_x),
        .sin_x      (sin_x),
        .sine       (sine),
        .cosine     (cosine)
    );

endmodule

/* bench/cordic_checker.sv */
`timescale 1ns/1ns

module cordic_checker (
    input logic                clk,
    input logic                rst_n,
    input cordic_pkg::sample_t sine,
    input cordic_pkg::sample_t cosine
);
    import cordic_pkg::*;

    // 64 is the unit circle, one more LSB for rounding
    localparam sample_t max_mag = sample_t'(65);

    a_reset_clears: assert property (
        @(posedge clk) !rst_n |=> (sine == '0 && cosine == '0)
    ) else $error("sine or cosine not cleared after a reset edge");

    // folded angles keep cosine in the right half plane
    a_cosine_sign: assert property (
        @(posedge clk) !$isunknown(cosine) |-> !cosine[sample_w-1]
    ) else $error("cosine went negative: %0d", cosine);

    a_magnitude: assert property (
        @(posedge clk) !$isunknown({sine, cosine}) |->
            (sine <= max_mag && sine >= -max_mag && cosine <= max_mag)
    ) else $error("output magnitude above 65: sine %0d cosine %0d", sine, cosine);

endmodule

bind cordic_top cordic_checker u_checker (
    .clk    (clk),
    .rst_n  (rst_n),
    .sine   (sine),
    .cosine (cosine)
);

/* bench/cordic_tb.sv */
`timescale 1ns/1ns

module cordic_tb;
    import cordic_pkg::*;

    localparam int num_stages = 12;
    // an angle driven at one falling edge shows up lat falling edges later
    localparam int lat        = num_stages + 2;
    localparam int clk_period = 40;
    localparam int rand_count = 20;
    localparam int tol        = 2;

    logic    clk = 1'b0;
    logic    rst_n;
    sample_t angle;
    sample_t sine;
    sample_t cosine;

    int          error_count;
    int          test_count;
    int          test_start_errors;
    bit          loaded;
    logic [15:0] lfsr_state;
    int          vec_angle[$];
    int          vec_sine[$];
    int          vec_cos[$];
    int          stim_q[$];
    int          got_sine[$];
    int          got_cos[$];

    cordic_top #(.num_stages(num_stages)) u_dut (
        .clk    (clk),
        .rst_n  (rst_n),
        .angle  (angle),
        .sine   (sine),
        .cosine (cosine)
    );

    always #(clk_period / 2) clk = ~clk;

    // galois form, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 16'hb400;
        end else begin
            return state >> 1;
        end
    endfunction

    task automatic draw_bits(input int width, output int value);
        int i;
        value = 0;
        for (i = 0; i < width; i++) begin
            value = (value << 1) | int'(lfsr_state[0]);
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic check_value(input string name, input int observed, input int expected,
                               input int margin);
        if (observed > expected + margin || observed < expected - margin) begin
            $display("CHECK FAILED %s at %0t ns: got 0x%02h, expected 0x%02h",
                     name, $time, observed[7:0], expected[7:0]);
            error_count++;
        end
    endtask

    task automatic check_vector(input int k, input int s, input int c);
        check_value($sformatf("sine(%0d)", vec_angle[k]), s, vec_sine[k], tol);
        check_value($sformatf("cosine(%0d)", vec_angle[k]), c, vec_cos[k], tol);
    endtask

    task automatic check_zero();
        check_value("sine", int'(sine), 0, 0);
        check_value("cosine", int'(cosine), 0, 0);
    endtask

    task automatic end_test(input string name);
        test_count++;
        if (error_count == test_start_errors) begin
            $display("test %0d (%s): ok", test_count, name);
        end else begin
            $display("test %0d (%s): %0d mismatches", test_count, name,
                     error_count - test_start_errors);
        end
        test_start_errors = error_count;
    endtask

    task automatic load_vectors();
        int    fd;
        int    a;
        int    s;
        int    c;
        string line;
        fd = $fopen("bench/sine_input.txt", "r");
        if (fd != 0) begin
            // comment lines hold no three numbers and drop out here
            while ($fgets(line, fd) != 0) begin
                if ($sscanf(line, "%d %d %d", a, s, c) == 3) begin
                    vec_angle.push_back(a);
                    vec_sine.push_back(s);
                    vec_cos.push_back(c);
                end
            end
            $fclose(fd);
        end
    endtask

    // one angle per cycle, results collected lat cycles behind
    task automatic run_capture();
        int t;
        got_sine.delete();
        got_cos.delete();
        for (t = 0; t < stim_q.size() + lat; t++) begin
            if (t >= lat) begin
                got_sine.push_back(int'(sine));
                got_cos.push_back(int'(cosine));
            end
            if (t < stim_q.size()) begin
                angle = sample_t'(stim_q[t]);
            end else begin
                angle = '0;
            end
            @(negedge clk);
        end
    endtask

    task automatic test_reset();
        int k;
        rst_n = 1'b0;
        angle = '0;
        repeat (10) begin
            @(negedge clk);
            check_zero();
        end
        rst_n = 1'b1;
        for (k = 1; k <= lat; k++) begin
            @(negedge clk);
            // at lat-1 the front-end reset residuals drain out
            if (k < lat - 1) begin
                check_zero();
            end else if (k == lat) begin
                check_value("sine", int'(sine), 0, tol);
                check_value("cosine", int'(cosine), 64, tol);
            end
        end
        end_test("reset");
    endtask

    task automatic test_single();
        int k;
        for (k = 0; k < vec_angle.size(); k++) begin
            angle = sample_t'(vec_angle[k]);
            repeat (lat) begin
                @(negedge clk);
                angle = '0;
            end
            check_vector(k, int'(sine), int'(cosine));
        end
        end_test("single vectors");
    endtask

    task automatic test_stream();
        int k;
        stim_q = vec_angle;
        run_capture();
        for (k = 0; k < vec_angle.size(); k++) begin
            check_vector(k, got_sine[k], got_cos[k]);
        end
        end_test("streaming");
    endtask

    task automatic test_symmetry();
        int i;
        int m;
        int exp_cos;
        int exp_sin;
        int mags[$];
        stim_q.delete();
        for (i = 0; i < rand_count; i++) begin
            draw_bits(7, m);
            m = m % 101;
            mags.push_back(m);
            stim_q.push_back(m);
            stim_q.push_back(-m);
        end
        run_capture();
        for (i = 0; i < rand_count; i++) begin
            m = mags[i];
            exp_cos = $rtoi(64.0 * $cos(real'(m) / 64.0) + 0.5);
            exp_sin = $rtoi(64.0 * $sin(real'(m) / 64.0) + 0.5);
            check_value($sformatf("sine(%0d)", m), got_sine[2*i], exp_sin, tol);
            check_value($sformatf("sine(-%0d)", m), got_sine[2*i+1], -got_sine[2*i], tol);
            check_value($sformatf("cosine(-%0d)", m), got_cos[2*i+1], got_cos[2*i], tol);
            check_value($sformatf("cosine(%0d)", m), got_cos[2*i], exp_cos, tol);
        end
        end_test("sign symmetry");
    endtask

    // reset pulse in the middle of a stream, then the rest of the file
    task automatic test_mid_reset();
        int n;
        int p;
        int rel;
        int t;
        n = vec_angle.size();
        p = n / 2;
        rel = p + 2;
        for (t = 0; t < rel + lat + n - p; t++) begin
            if (t >= lat && t <= p) begin
                check_vector(t - lat, int'(sine), int'(cosine));
            end else if (t > p && t < rel + lat - 1) begin
                check_zero();
            end else if (t >= rel + lat) begin
                check_vector(p + t - rel - lat, int'(sine), int'(cosine));
            end
            if (t == p) begin
                rst_n = 1'b0;
            end else if (t == rel) begin
                rst_n = 1'b1;
            end
            if (t < p) begin
                angle = sample_t'(vec_angle[t]);
            end else if (t >= rel && t < rel + n - p) begin
                angle = sample_t'(vec_angle[p + t - rel]);
            end else begin
                angle = '0;
            end
            @(negedge clk);
        end
        end_test("mid-stream reset");
    endtask

    initial begin
        longint budget_ns;
        wait (loaded);
        budget_ns = longint'(vec_angle.size() * (lat + 2) + 2 * rand_count + 8 * lat + 100)
                    * clk_period;
        #(budget_ns);
        $display("timeout: simulation still running after %0d ns", budget_ns);
        $display("Errors found");
        $finish;
    end

    initial begin
        rst_n = 1'b0;
        angle = '0;
        error_count = 0;
        test_count = 0;
        test_start_errors = 0;
        lfsr_state = 16'd3;
        load_vectors();
        loaded = (vec_angle.size() > 0);
        if (!loaded) begin
            $display("no test vectors could be read from bench/sine_input.txt");
            error_count++;
        end else begin
            test_reset();
            test_single();
            test_stream();
            test_symmetry();
            test_mid_reset();
        end
        $display("summary: %0d tests run, %0d mismatches", test_count, error_count);
        if (error_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* bench/sine_input.txt */
// angle code (Q1.6 rad), expected sine, expected cosine, all decimal
// sine = round(64*sin(a/64)), cosine = round(64*cos(a/64))
0 0 64
1 1 64
-1 -1 64
2 2 64
-2 -2 64
5 5 64
-5 -5 64
8 8 64
10 10 63
-10 -10 63
16 16 62
20 20 61
-25 -24 59
30 29 57
32 31 56
-32 -31 56
40 37 52
-45 -41 49
48 44 47
50 45 45
-50 -45 45
55 48 42
-60 -52 38
64 54 35
-64 -54 35
70 57 29
75 59 25
-80 -61 20
85 62 15
90 63 10
-90 -63 10
95 64 6
100 64 1
-100 -64 1

/* flist.f */
source/cordic_pkg.sv
source/angle_prep.sv
source/cordic_stage.sv
source/cordic_rotator.sv
source/result_combine.sv
source/cordic_top.sv
bench/cordic_checker.sv
bench/cordic_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= cordic_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FLIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run check clean

all: check

$(BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	$(BIN) 2>&1 | tee $(LOG)

check: run
	@if grep -q "No errors" $(LOG); then echo "PASS: $(TOP)"; else echo "FAIL: $(TOP)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
